//--- tests/caravel_host_input.txt
// op address wdata expected, one transaction per line, all hex
// op 0 write (expected = min ack cycles), 1 read (wdata = mask), 2 outside probe, 3 poll, F end
1 3F100008 FFFFFFFF 00000000
1 3F10000C FFFFFFFF 00000008
1 30001234 FFFFFFFF 5A5A486E
0 30000010 DEADBEEF 00000000
1 3ABCDEF0 FFFFFFFF 50E684AA
2 20000000 00000000 00000000
2 2F100008 00000000 00000000
2 40001000 00000000 00000000
1 3F20000C FFFFFFFF 00000000
// Loopback of one byte at the reset divisor
0 3F100000 000000A5 00000000
3 3F100008 00000002 00000002
1 3F100004 FFFFFFFF 000001A5
1 3F100008 00000002 00000000
0 3F10000C 0000000A 00000000
1 3F10000C FFFFFFFF 0000000A
// Second write waits for the first frame
0 3F100000 0000003C 00000000
0 3F100000 000000C3 00000040
3 3F100008 00000002 00000002
1 3F100004 FFFFFFFF 0000013C
3 3F100008 00000002 00000002
1 3F100004 FFFFFFFF 000001C3
1 3F100008 FFFFFFFF 00000000
F 00000000 00000000 00000000

//--- caravel_host.f
src/caravel_host_pkg.sv
src/wb_periph_bridge.sv
src/uart_baud_timer.sv
src/uart_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/caravel_host.sv
tests/caravel_host_checker.sv
tests/caravel_host_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := caravel_host_tb
FILELIST   := caravel_host.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/caravel_host_tb.sv
`timescale 1ns/1ns
`default_nettype none

module caravel_host_tb
	import caravel_host_pkg::*;
();

	localparam int HALF_PERIOD      = 10;
	localparam int CLK_PERIOD       = 2 * HALF_PERIOD;
	localparam int RESET_CYCLES     = 3;
	localparam int MAX_TRANS        = 64;
	localparam int FRAMES_PER_TRANS = 12;
	localparam int PROBE_CYCLES     = 4;

	// Operation codes of the first column in the input file
	localparam logic [31:0] OP_WRITE = 32'h0;
	localparam logic [31:0] OP_READ  = 32'h1;
	localparam logic [31:0] OP_PROBE = 32'h2;
	localparam logic [31:0] OP_POLL  = 32'h3;
	localparam logic [31:0] OP_END   = 32'hF;

	// Outgoing slave returns its 28-bit address XOR this word
	localparam wb_data_t MODEL_XOR = 32'h5A5A5A5A;

	localparam wb_sel_t FULL_SEL = 4'hF;

	logic       wb_clk_i          = 1'b0;
	logic       arst_n_i          = 1'b0;
	logic       wbs_cyc_i         = 1'b0;
	logic       wbs_stb_i         = 1'b0;
	logic       wbs_we_i          = 1'b0;
	wb_sel_t    wbs_sel_i         = '0;
	wb_addr_t   wbs_adr_i         = '0;
	wb_data_t   wbs_data_i        = '0;
	logic       caravel_wb_ack_i  = 1'b0;
	wb_data_t   caravel_wb_data_i = '0;
	logic       wbs_ack_o;
	wb_data_t   wbs_data_o;
	logic       caravel_wb_cyc_o;
	logic       caravel_wb_stb_o;
	logic       caravel_wb_we_o;
	wb_sel_t    caravel_wb_sel_o;
	user_addr_t caravel_wb_adr_o;
	wb_data_t   caravel_wb_data_o;
	wire        uart_line;

	logic [31:0] trans_mem [0:4*MAX_TRANS-1];
	int          trans_count   = 0;
	longint      timeout_ns    = 0;
	int          ack_count     = 0;
	int          acks_expected = 0;
	logic        saw_pass_stb;
	logic        saw_pass_cyc;
	user_addr_t  pass_adr_seen;
	logic        pass_we_seen;
	wb_sel_t     pass_sel_seen;
	wb_data_t    pass_data_seen;

	always #HALF_PERIOD wb_clk_i = ~wb_clk_i;

	caravel_host dut (
		.wb_clk_i          (wb_clk_i),
		.arst_n_i          (arst_n_i),
		.wbs_cyc_i         (wbs_cyc_i),
		.wbs_stb_i         (wbs_stb_i),
		.wbs_we_i          (wbs_we_i),
		.wbs_sel_i         (wbs_sel_i),
		.wbs_adr_i         (wbs_adr_i),
		.wbs_data_i        (wbs_data_i),
		.wbs_ack_o         (wbs_ack_o),
		.wbs_data_o        (wbs_data_o),
		.caravel_wb_cyc_o  (caravel_wb_cyc_o),
		.caravel_wb_stb_o  (caravel_wb_stb_o),
		.caravel_wb_we_o   (caravel_wb_we_o),
		.caravel_wb_sel_o  (caravel_wb_sel_o),
		.caravel_wb_adr_o  (caravel_wb_adr_o),
		.caravel_wb_data_o (caravel_wb_data_o),
		.caravel_wb_ack_i  (caravel_wb_ack_i),
		.caravel_wb_data_i (caravel_wb_data_i),
		.uart_rx_i         (uart_line),
		.uart_tx_o         (uart_line)
	);

	bind wb_periph_bridge caravel_host_checker u_checker (
		.wb_clk_i    (wb_clk_i),
		.arst_n_i    (arst_n_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_ack_o    (wb_ack_o),
		.pbus_we_o   (pbus_we_o),
		.pbus_oe_o   (pbus_oe_o),
		.pbus_busy_i (pbus_busy_i)
	);

	// Outgoing slave model acks one cycle after stb
	always @(posedge wb_clk_i) begin
		caravel_wb_ack_i  <= caravel_wb_stb_o && !caravel_wb_ack_i;
		caravel_wb_data_i <= {4'h0, caravel_wb_adr_o} ^ MODEL_XOR;
	end

	always @(posedge wb_clk_i) begin
		if (wbs_ack_o) begin
			ack_count <= ack_count + 1;
		end
	end

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s, got %08h, expected %08h", $time, what, actual,
				expected);
			$display("Result: FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic bus_access(input logic is_write, input wb_addr_t addr, input wb_data_t wdata,
			output wb_data_t rdata, output int cycles);
		cycles       = 0;
		saw_pass_stb = 1'b0;
		saw_pass_cyc = 1'b0;
		wbs_cyc_i  <= 1'b1;
		wbs_stb_i  <= 1'b1;
		wbs_we_i   <= is_write;
		wbs_sel_i  <= FULL_SEL;
		wbs_adr_i  <= addr;
		wbs_data_i <= wdata;
		do begin
			@(posedge wb_clk_i);
			cycles++;
			if (caravel_wb_cyc_o) begin
				saw_pass_cyc = 1'b1;
			end
			if (caravel_wb_stb_o) begin
				saw_pass_stb   = 1'b1;
				pass_adr_seen  = caravel_wb_adr_o;
				pass_we_seen   = caravel_wb_we_o;
				pass_sel_seen  = caravel_wb_sel_o;
				pass_data_seen = caravel_wb_data_o;
			end
		end while (!wbs_ack_o);
		rdata = wbs_data_o;
		acks_expected++;
		wbs_cyc_i <= 1'b0;
		wbs_stb_i <= 1'b0;
		wbs_we_i  <= 1'b0;
		@(posedge wb_clk_i);
		check_value("slave ack dropped after one cycle", {31'd0, wbs_ack_o}, 32'd0);
	endtask

	// Nothing may answer an address outside the user space
	task automatic probe_outside(input wb_addr_t addr);
		wbs_cyc_i <= 1'b1;
		wbs_stb_i <= 1'b1;
		wbs_we_i  <= 1'b0;
		wbs_sel_i <= FULL_SEL;
		wbs_adr_i <= addr;
		repeat (PROBE_CYCLES) begin
			@(posedge wb_clk_i);
			check_value($sformatf("master cycle for %08h", addr), {31'd0, caravel_wb_cyc_o},
				32'd0);
			check_value($sformatf("master strobe for %08h", addr), {31'd0, caravel_wb_stb_o},
				32'd0);
			check_value($sformatf("slave ack for %08h", addr), {31'd0, wbs_ack_o}, 32'd0);
		end
		wbs_cyc_i <= 1'b0;
		wbs_stb_i <= 1'b0;
		@(posedge wb_clk_i);
	endtask

	task automatic inspect_master_port(input logic to_master, input logic is_write,
			input wb_addr_t addr, input wb_data_t wdata);
		check_value($sformatf("master cycle seen for %08h", addr), {31'd0, saw_pass_cyc},
			{31'd0, to_master});
		check_value($sformatf("master strobe seen for %08h", addr), {31'd0, saw_pass_stb},
			{31'd0, to_master});
		if (to_master) begin
			check_value("master address", {4'd0, pass_adr_seen}, {4'd0, addr[27:0]});
			check_value("master write enable", {31'd0, pass_we_seen}, {31'd0, is_write});
			check_value("master byte select", {28'd0, pass_sel_seen}, {28'd0, FULL_SEL});
			if (is_write) begin
				check_value("master write data", pass_data_seen, wdata);
			end
		end
	endtask

	task automatic run_transaction(input int idx);
		logic [31:0] op;
		wb_addr_t    addr;
		wb_data_t    wdata;
		wb_data_t    expected;
		wb_data_t    rdata;
		int          cycles;
		logic        to_master;

		op        = trans_mem[4*idx];
		addr      = trans_mem[4*idx+1];
		wdata     = trans_mem[4*idx+2];
		expected  = trans_mem[4*idx+3];
		to_master = (addr[31:28] == USER_SPACE_ID) && (addr[27:24] != HOST_WINDOW_ID);
		case (op)
			OP_WRITE: begin
				bus_access(1'b1, addr, wdata, rdata, cycles);
				inspect_master_port(to_master, 1'b1, addr, wdata);
				// A nonzero last column on a write is its minimum ack latency
				if (expected != 0) begin
					check_value($sformatf("write to %08h acked after %0d cycles, minimum %0d",
						addr, cycles, expected), {31'd0, cycles >= expected}, 32'd1);
				end
			end
			OP_READ: begin
				bus_access(1'b0, addr, '0, rdata, cycles);
				inspect_master_port(to_master, 1'b0, addr, '0);
				check_value($sformatf("read data at %08h", addr), rdata & wdata, expected);
			end
			OP_PROBE: begin
				probe_outside(addr);
			end
			OP_POLL: begin
				do begin
					bus_access(1'b0, addr, '0, rdata, cycles);
					inspect_master_port(to_master, 1'b0, addr, '0);
				end while ((rdata & wdata) != expected);
			end
			default: begin
				$display("Unknown operation %0h in entry %0d of the input file", op, idx);
				$display("Result: FAILED");
				$fatal(1, "bad input file");
			end
		endcase
	endtask

	// Watchdog armed once the test length is known
	initial begin
		wait (timeout_ns != 0);
		#(timeout_ns);
		$display("Timeout after %0d ns, the DUT stopped answering", timeout_ns);
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		baud_div_t max_div;
		int        idx;

		$readmemh("tests/caravel_host_input.txt", trans_mem);
		while (trans_count < MAX_TRANS && trans_mem[4*trans_count] !== OP_END) begin
			trans_count++;
		end
		if (trans_count == 0 || trans_count == MAX_TRANS) begin
			$display("Input file is missing, empty or has no end marker");
			$display("Result: FAILED");
			$fatal(1, "bad input file");
		end
		// Slowest baud in the file sets the time budget
		max_div = UART_BAUD_RESET;
		for (idx = 0; idx < trans_count; idx++) begin
			if (trans_mem[4*idx] == OP_WRITE && trans_mem[4*idx+1][27:24] == HOST_WINDOW_ID &&
				trans_mem[4*idx+1][3:0] == UART_BAUD_OFS &&
				trans_mem[4*idx+2][15:0] > max_div) begin
				max_div = trans_mem[4*idx+2][15:0];
			end
		end
		timeout_ns = longint'(trans_count) * longint'(FRAMES_PER_TRANS) *
			longint'(max_div) * longint'(CLK_PERIOD);

		repeat (RESET_CYCLES) @(posedge wb_clk_i);
		arst_n_i <= 1'b1;
		@(posedge wb_clk_i);
		for (idx = 0; idx < trans_count; idx++) begin
			run_transaction(idx);
		end
		check_value("acks seen on the slave port", ack_count, acks_expected);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/caravel_host_checker.sv
`timescale 1ns/1ns
`default_nettype none

module caravel_host_checker (
	input wire wb_clk_i,
	input wire arst_n_i,
	input wire wb_stb_i,
	input wire wb_we_i,
	input wire wb_ack_o,
	input wire pbus_we_o,
	input wire pbus_oe_o,
	input wire pbus_busy_i
);

	// Ack ends the access and the gated request drops with it
	property ack_single_cycle;
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		wb_ack_o |=> !wb_ack_o && !wb_stb_i;
	endproperty

	// One strobe only, in the direction of the request still held
	property strobe_matches_request;
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		(pbus_we_o || pbus_oe_o) |->
			wb_stb_i && (pbus_we_o == wb_we_i) && (pbus_oe_o == !wb_we_i);
	endproperty

	// Without busy the ack follows the pulse while the request still stands
	property pulse_then_ack;
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		(pbus_we_o || pbus_oe_o) |=> pbus_busy_i || (wb_ack_o && wb_stb_i);
	endproperty

	a_ack_single_cycle: assert property (ack_single_cycle)
		else $error("bridge ack held high or request still active after the ack");

	a_strobe_matches_request: assert property (strobe_matches_request)
		else $error("peripheral strobe does not match the held request");

	a_pulse_then_ack: assert property (pulse_then_ack)
		else $error("no bridge ack after a peripheral pulse with busy low");

endmodule

`default_nettype wire

//--- src/caravel_host.sv
`timescale 1ns/1ns
`default_nettype none

module caravel_host
	import caravel_host_pkg::*;
(
	input  wire             wb_clk_i,
	input  wire             arst_n_i,
	input  wire             wbs_cyc_i,
	input  wire             wbs_stb_i,
	input  wire             wbs_we_i,
	input  wire wb_sel_t    wbs_sel_i,
	input  wire wb_addr_t   wbs_adr_i,
	input  wire wb_data_t   wbs_data_i,
	output logic            wbs_ack_o,
	output wb_data_t        wbs_data_o,
	output logic            caravel_wb_cyc_o,
	output logic            caravel_wb_stb_o,
	output logic            caravel_wb_we_o,
	output wb_sel_t         caravel_wb_sel_o,
	output user_addr_t      caravel_wb_adr_o,
	output wb_data_t        caravel_wb_data_o,
	input  wire             caravel_wb_ack_i,
	input  wire wb_data_t   caravel_wb_data_i,
	input  wire             uart_rx_i,
	output logic            uart_tx_o
);

	logic       user_space;
	logic       host_window;
	logic       pass_sel;
	logic       host_sel;
	logic       bridge_ack;
	wb_data_t   bridge_data;

	logic       pbus_we;
	logic       pbus_oe;
	logic       pbus_busy;
	pbus_addr_t pbus_addr;
	wb_sel_t    pbus_sel;
	wb_data_t   pbus_wdata;
	wb_data_t   pbus_rdata;

	logic       tx_load;
	byte_t      tx_data;
	logic       tx_busy;
	logic       tx_start;
	baud_div_t  baud_div;
	logic       bit_tick;
	logic       sample_tick;
	logic       rx_start;
	byte_t      rx_data;
	logic       rx_valid;
	logic       rx_clear;

	assign user_space  = wbs_adr_i[31:28] == USER_SPACE_ID;
	assign host_window = wbs_adr_i[27:24] == HOST_WINDOW_ID;
	assign pass_sel    = user_space && !host_window;

	// Straight pass-through to the user project master port
	assign caravel_wb_cyc_o  = wbs_cyc_i && pass_sel;
	assign caravel_wb_stb_o  = wbs_stb_i && pass_sel;
	assign caravel_wb_we_o   = wbs_we_i;
	assign caravel_wb_sel_o  = wbs_sel_i;
	assign caravel_wb_adr_o  = wbs_adr_i[27:0];
	assign caravel_wb_data_o = wbs_data_i;

	// Held for the whole host-window access, dropped on the bridge ack
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			host_sel <= 1'b0;
		end else if (bridge_ack) begin
			host_sel <= 1'b0;
		end else if (wbs_cyc_i && wbs_stb_i && user_space && host_window) begin
			host_sel <= 1'b1;
		end
	end

	assign wbs_ack_o  = host_sel ? bridge_ack  : caravel_wb_ack_i;
	assign wbs_data_o = host_sel ? bridge_data : caravel_wb_data_i;

	wb_periph_bridge u_bridge (
		.wb_clk_i     (wb_clk_i),
		.arst_n_i     (arst_n_i),
		.wb_cyc_i     (wbs_cyc_i && host_sel),
		.wb_stb_i     (wbs_stb_i && host_sel),
		.wb_we_i      (wbs_we_i),
		.wb_sel_i     (wbs_sel_i),
		.wb_adr_i     (wbs_adr_i[23:0]),
		.wb_data_i    (wbs_data_i),
		.wb_ack_o     (bridge_ack),
		.wb_data_o    (bridge_data),
		.pbus_we_o    (pbus_we),
		.pbus_oe_o    (pbus_oe),
		.pbus_addr_o  (pbus_addr),
		.pbus_sel_o   (pbus_sel),
		.pbus_wdata_o (pbus_wdata),
		.pbus_rdata_i (pbus_rdata),
		.pbus_busy_i  (pbus_busy)
	);

	uart_regs u_regs (
		.wb_clk_i     (wb_clk_i),
		.arst_n_i     (arst_n_i),
		.pbus_we_i    (pbus_we),
		.pbus_oe_i    (pbus_oe),
		.pbus_addr_i  (pbus_addr),
		.pbus_sel_i   (pbus_sel),
		.pbus_wdata_i (pbus_wdata),
		.pbus_rdata_o (pbus_rdata),
		.pbus_busy_o  (pbus_busy),
		.tx_busy_i    (tx_busy),
		.tx_load_o    (tx_load),
		.tx_data_o    (tx_data),
		.baud_div_o   (baud_div),
		.rx_data_i    (rx_data),
		.rx_valid_i   (rx_valid),
		.rx_clear_o   (rx_clear)
	);

	uart_baud_timer u_baud (
		.wb_clk_i      (wb_clk_i),
		.arst_n_i      (arst_n_i),
		.baud_div_i    (baud_div),
		.tx_start_i    (tx_start),
		.rx_start_i    (rx_start),
		.bit_tick_o    (bit_tick),
		.sample_tick_o (sample_tick)
	);

	uart_tx u_tx (
		.wb_clk_i   (wb_clk_i),
		.arst_n_i   (arst_n_i),
		.load_i     (tx_load),
		.data_i     (tx_data),
		.bit_tick_i (bit_tick),
		.tx_start_o (tx_start),
		.busy_o     (tx_busy),
		.tx_o       (uart_tx_o)
	);

	uart_rx u_rx (
		.wb_clk_i      (wb_clk_i),
		.arst_n_i      (arst_n_i),
		.rx_i          (uart_rx_i),
		.sample_tick_i (sample_tick),
		.clear_i       (rx_clear),
		.rx_start_o    (rx_start),
		.data_o        (rx_data),
		.valid_o       (rx_valid)
	);

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
	import caravel_host_pkg::*;
(
	input  wire  wb_clk_i,
	input  wire  arst_n_i,
	input  wire  rx_i,
	input  wire  sample_tick_i,
	input  wire  clear_i,
	output logic rx_start_o,
	output byte_t data_o,
	output logic valid_o
);

	uart_rx_state_t state;
	logic [2:0]     rx_sync;
	logic           rx_bit;
	byte_t          shift_q;
	logic [2:0]     bit_cnt;

	// Two sync flops plus one more for edge detect
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rx_sync <= 3'b111;
		end else begin
			rx_sync <= {rx_sync[1:0], rx_i};
		end
	end

	assign rx_bit     = rx_sync[1];
	assign rx_start_o = (state == RX_IDLE) && rx_sync[2] && !rx_bit;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state   <= RX_IDLE;
			bit_cnt <= '0;
			valid_o <= 1'b0;
		end else begin
			if (clear_i) begin
				valid_o <= 1'b0;
			end
			case (state)
				RX_IDLE:
					if (rx_start_o) begin
						state <= RX_START;
					end
				// Glitch on the line if start bit is gone by mid-bit
				RX_START:
					if (sample_tick_i) begin
						bit_cnt <= '0;
						state   <= rx_bit ? RX_IDLE : RX_DATA;
					end
				RX_DATA:
					if (sample_tick_i) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= RX_STOP;
						end
					end
				RX_STOP:
					if (sample_tick_i) begin
						if (rx_bit) begin
							valid_o <= 1'b1;
						end
						state <= RX_IDLE;
					end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (state == RX_DATA && sample_tick_i) begin
			shift_q <= {rx_bit, shift_q[7:1]};
		end
		if (state == RX_STOP && sample_tick_i && rx_bit) begin
			data_o <= shift_q;
		end
	end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
	import caravel_host_pkg::*;
(
	input  wire        wb_clk_i,
	input  wire        arst_n_i,
	input  wire        load_i,
	input  wire byte_t data_i,
	input  wire        bit_tick_i,
	output logic       tx_start_o,
	output logic       busy_o,
	output logic       tx_o
);

	uart_tx_state_t state;
	byte_t          shift_q;
	logic [2:0]     bit_cnt;

	assign tx_start_o = (state == TX_IDLE) && load_i;
	assign busy_o     = state != TX_IDLE;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state   <= TX_IDLE;
			tx_o    <= 1'b1;
			bit_cnt <= '0;
		end else begin
			case (state)
				TX_IDLE:
					if (load_i) begin
						tx_o  <= 1'b0;
						state <= TX_START;
					end
				TX_START:
					if (bit_tick_i) begin
						tx_o    <= shift_q[0];
						bit_cnt <= '0;
						state   <= TX_DATA;
					end
				// LSB first, shift register moves on each tick
				TX_DATA:
					if (bit_tick_i) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							tx_o  <= 1'b1;
							state <= TX_STOP;
						end else begin
							tx_o <= shift_q[1];
						end
					end
				TX_STOP:
					if (bit_tick_i) begin
						state <= TX_IDLE;
					end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (tx_start_o) begin
			shift_q <= data_i;
		end else if (state == TX_DATA && bit_tick_i) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

endmodule

`default_nettype wire

//--- src/uart_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_regs
	import caravel_host_pkg::*;
(
	input  wire             wb_clk_i,
	input  wire             arst_n_i,
	input  wire             pbus_we_i,
	input  wire             pbus_oe_i,
	input  wire pbus_addr_t pbus_addr_i,
	input  wire wb_sel_t    pbus_sel_i,
	input  wire wb_data_t   pbus_wdata_i,
	output wb_data_t        pbus_rdata_o,
	output logic            pbus_busy_o,
	input  wire             tx_busy_i,
	output logic            tx_load_o,
	output byte_t           tx_data_o,
	output baud_div_t       baud_div_o,
	input  wire byte_t      rx_data_i,
	input  wire             rx_valid_i,
	output logic            rx_clear_o
);

	logic     id_match;
	logic     wr_txdata;
	logic     wr_baud;
	logic     tx_pend;
	wb_data_t rdata_next;

	assign id_match  = pbus_addr_i[23:20] == UART_PERIPH_ID;
	assign wr_txdata = pbus_we_i && id_match && pbus_addr_i[3:0] == UART_TXDATA_OFS &&
		pbus_sel_i[0];
	assign wr_baud   = pbus_we_i && id_match && pbus_addr_i[3:0] == UART_BAUD_OFS &&
		pbus_sel_i[1:0] == 2'b11;

	// Reading the RX data register consumes the byte
	assign rx_clear_o = pbus_oe_i && id_match && pbus_addr_i[3:0] == UART_RXDATA_OFS;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tx_pend    <= 1'b0;
			tx_load_o  <= 1'b0;
			baud_div_o <= UART_BAUD_RESET;
		end else begin
			tx_load_o <= 1'b0;
			if (wr_baud) begin
				baud_div_o <= pbus_wdata_i[15:0];
			end
			// Transmitter busy: hold the bus until the frame ends
			if ((wr_txdata || tx_pend) && !tx_busy_i) begin
				tx_load_o <= 1'b1;
				tx_pend   <= 1'b0;
			end else if (wr_txdata) begin
				tx_pend <= 1'b1;
			end
		end
	end

	assign pbus_busy_o = tx_pend;

	always_ff @(posedge wb_clk_i) begin
		if (wr_txdata) begin
			tx_data_o <= pbus_wdata_i[7:0];
		end
	end

	always_comb begin
		rdata_next = '0;
		if (id_match) begin
			case (pbus_addr_i[3:0])
				UART_RXDATA_OFS: rdata_next = {23'd0, rx_valid_i, rx_data_i};
				UART_STATUS_OFS: rdata_next = {30'd0, rx_valid_i, tx_busy_i};
				UART_BAUD_OFS:   rdata_next = {16'd0, baud_div_o};
				default:         rdata_next = '0;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (pbus_oe_i) begin
			pbus_rdata_o <= rdata_next;
		end
	end

endmodule

`default_nettype wire

//--- src/uart_baud_timer.sv
`timescale 1ns/1ns
`default_nettype none

module uart_baud_timer
	import caravel_host_pkg::*;
(
	input  wire            wb_clk_i,
	input  wire            arst_n_i,
	input  wire baud_div_t baud_div_i,
	input  wire            tx_start_i,
	input  wire            rx_start_i,
	output logic           bit_tick_o,
	output logic           sample_tick_o
);

	baud_div_t tx_cnt;
	baud_div_t rx_cnt;
	baud_div_t period;
	baud_div_t half_period;

	assign period      = baud_div_i - 16'd1;
	assign half_period = {1'b0, baud_div_i[15:1]} - 16'd1;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tx_cnt <= '0;
			rx_cnt <= '0;
		end else begin
			if (tx_start_i || tx_cnt == '0) begin
				tx_cnt <= period;
			end else begin
				tx_cnt <= tx_cnt - 16'd1;
			end
			// First receive period is half a bit to land mid-bit
			if (rx_start_i) begin
				rx_cnt <= half_period;
			end else if (rx_cnt == '0) begin
				rx_cnt <= period;
			end else begin
				rx_cnt <= rx_cnt - 16'd1;
			end
		end
	end

	assign bit_tick_o    = (tx_cnt == '0) && !tx_start_i;
	assign sample_tick_o = (rx_cnt == '0) && !rx_start_i;

endmodule

`default_nettype wire

//--- src/wb_periph_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module wb_periph_bridge
	import caravel_host_pkg::*;
(
	input  wire             wb_clk_i,
	input  wire             arst_n_i,
	input  wire             wb_cyc_i,
	input  wire             wb_stb_i,
	input  wire             wb_we_i,
	input  wire wb_sel_t    wb_sel_i,
	input  wire pbus_addr_t wb_adr_i,
	input  wire wb_data_t   wb_data_i,
	output logic            wb_ack_o,
	output wb_data_t        wb_data_o,
	output logic            pbus_we_o,
	output logic            pbus_oe_o,
	output pbus_addr_t      pbus_addr_o,
	output wb_sel_t         pbus_sel_o,
	output wb_data_t        pbus_wdata_o,
	input  wire wb_data_t   pbus_rdata_i,
	input  wire             pbus_busy_i
);

	bridge_state_t state;
	logic          we_q;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= BR_IDLE;
		end else begin
			case (state)
				BR_IDLE:
					if (wb_cyc_i && wb_stb_i) begin
						state <= BR_ACCESS;
					end
				BR_ACCESS:
					state <= BR_RESPOND;
				// Peripheral asked for more time, wait for it
				BR_WAIT_BUSY:
					if (!pbus_busy_i) begin
						state <= BR_RESPOND;
					end
				BR_RESPOND:
					if (pbus_busy_i) begin
						state <= BR_WAIT_BUSY;
					end else begin
						state <= BR_IDLE;
					end
				default:
					state <= BR_IDLE;
			endcase
		end
	end

	// Request captured once, held stable until the ack
	always_ff @(posedge wb_clk_i) begin
		if (state == BR_IDLE && wb_cyc_i && wb_stb_i) begin
			we_q         <= wb_we_i;
			pbus_addr_o  <= wb_adr_i;
			pbus_sel_o   <= wb_sel_i;
			pbus_wdata_o <= wb_data_i;
		end
	end

	assign pbus_we_o = (state == BR_ACCESS) && we_q;
	assign pbus_oe_o = (state == BR_ACCESS) && !we_q;

	// Read data from the peripheral is registered, so it is valid here
	assign wb_ack_o  = (state == BR_RESPOND) && !pbus_busy_i;
	assign wb_data_o = wb_ack_o ? pbus_rdata_i : '0;

endmodule

`default_nettype wire

//--- src/caravel_host_pkg.sv
`default_nettype none

package caravel_host_pkg;

	typedef logic [31:0] wb_data_t;
	typedef logic [31:0] wb_addr_t;
	typedef logic [3:0]  wb_sel_t;
	typedef logic [27:0] user_addr_t;
	typedef logic [23:0] pbus_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] baud_div_t;

	// Address map tags on wbs_adr_i[31:28] and [27:24]
	localparam logic [3:0] USER_SPACE_ID  = 4'h3;
	localparam logic [3:0] HOST_WINDOW_ID = 4'hF;

	// Peripheral ID sits on pbus address bits 23:20
	localparam logic [3:0] UART_PERIPH_ID = 4'h1;

	localparam logic [3:0] UART_TXDATA_OFS = 4'h0;
	localparam logic [3:0] UART_RXDATA_OFS = 4'h4;
	localparam logic [3:0] UART_STATUS_OFS = 4'h8;
	localparam logic [3:0] UART_BAUD_OFS   = 4'hC;

	// Clocks per bit
	localparam baud_div_t UART_BAUD_RESET = 16'd8;

	typedef enum logic [1:0] {BR_IDLE, BR_ACCESS, BR_WAIT_BUSY, BR_RESPOND} bridge_state_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_t;

endpackage

`default_nettype wire
